// ==== bench/tbCpuBus.sv ====
////////////////////
// CPU bus testbench
// Runs register, RAM and unmapped cycles and checks every beat and read
////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "cpuBus_params.svh"

module tbCpuBus;

    localparam int clkPeriod    = 40;
    localparam int preloadLines = 64;   // Fills the whole RAM so every read is defined
    localparam int randomWrites = 16;
    localparam int mixedCycles  = 40;
    localparam int totalCycles  = 6 + preloadLines + 2 * randomWrites + mixedCycles;

    logic CLK40;
    logic nRESET;
    logic nTS;
    logic nRW;
    logic nTA;
    logic taDrive;
    logic nTBI;
    logic tbiDrive;
    logic nTEA;
    cpuBusPkg::cpuAddr  address;
    cpuBusPkg::sizeCode siz;
    cpuBusPkg::cpuData  dataIn;
    cpuBusPkg::cpuData  dataOut;

    cpuBusPkg::cpuData  regModel [8];
    cpuBusPkg::cpuData  ramModel [`RAM_WORDS];
    cpuBusPkg::cpuData  gotQ [$];          // Read beats seen on the bus
    cpuBusPkg::cpuData  wantQ [$];         // Values the model predicts for them
    cpuBusPkg::cpuAddr  testAddr [randomWrites];
    cpuBusPkg::sizeCode testSize [randomWrites];
    cpuBusPkg::cpuData  got;
    cpuBusPkg::cpuData  want;
    int mismatches     = 0;
    int protocolErrors = 0;

    cpuBusTop dut0 (
        .CLK40(CLK40), .nRESET(nRESET), .nTS(nTS), .address(address), .nRW(nRW),
        .siz(siz), .dataIn(dataIn), .dataOut(dataOut), .nTA(nTA), .taDrive(taDrive),
        .nTBI(nTBI), .tbiDrive(tbiDrive), .nTEA(nTEA)
    );

    initial begin
        CLK40 = 1'b0;
        forever #(clkPeriod / 2) CLK40 = ~CLK40;
    end

    //////////////////////
    // Reference model
    //////////////////////

    function automatic cpuBusPkg::busSpace classifySpace(input cpuBusPkg::cpuAddr addr);
        if (addr >= `REG_BASE && addr < `REG_BASE + 32'd32)
            return cpuBusPkg::spaceReg;   // Eight longword registers
        if (addr >= `RAM_BASE && addr < `RAM_BASE + 32'(`RAM_WORDS * 4))
            return cpuBusPkg::spaceRam;
        return cpuBusPkg::spaceBad;
    endfunction

    // Word touched by a RAM beat where lines start at the aligned word and count up
    function automatic cpuBusPkg::ramIndex ramSlot(input cpuBusPkg::cpuAddr addr,
                                                   input cpuBusPkg::sizeCode size,
                                                   input int beat);
        int offset;
        offset = int'((addr - `RAM_BASE) >> 2);
        if (size == cpuBusPkg::sizeLine)
            offset = (offset & ~(`LINE_BEATS - 1)) + beat;
        return cpuBusPkg::ramIndex'(offset % `RAM_WORDS);
    endfunction

    function automatic cpuBusPkg::cpuData expectRead(input cpuBusPkg::cpuAddr addr,
                                                     input cpuBusPkg::sizeCode size,
                                                     input int beat);
        if (classifySpace(addr) == cpuBusPkg::spaceReg)
            return regModel[cpuBusPkg::regIndex'((addr - `REG_BASE) >> 2)];
        return ramModel[ramSlot(addr, size, beat)];
    endfunction

    function automatic void recordWrite(input cpuBusPkg::cpuAddr addr,
                                        input cpuBusPkg::sizeCode size,
                                        input int beat, input cpuBusPkg::cpuData data);
        if (classifySpace(addr) == cpuBusPkg::spaceReg)
            regModel[cpuBusPkg::regIndex'((addr - `REG_BASE) >> 2)] = data;
        else if (classifySpace(addr) == cpuBusPkg::spaceRam)
            ramModel[ramSlot(addr, size, beat)] = data;
    endfunction

    //////////////////////
    // Bus cycles
    //////////////////////

    // Runs one CPU cycle with clk counting clocks from the edge that samples nTS low
    task automatic runCycle(input cpuBusPkg::cpuAddr addr, input logic write,
                            input cpuBusPkg::sizeCode size);
        cpuBusPkg::cpuData  beatData [4];
        cpuBusPkg::busSpace kind;
        int  wantBeats;
        int  firstClk;
        int  beats;
        int  clk;
        int  idle;
        bit  done;
        bit  inhibit;
        kind      = classifySpace(addr);
        inhibit   = (kind == cpuBusPkg::spaceReg) && (size == cpuBusPkg::sizeLine);
        firstClk  = (kind == cpuBusPkg::spaceReg) ? 1 + `REG_WAIT :
                    (kind == cpuBusPkg::spaceRam) ? 1 + `RAM_FIRST_WAIT : 2;
        wantBeats = (kind == cpuBusPkg::spaceBad) ? 0 :
                    (kind == cpuBusPkg::spaceRam && size == cpuBusPkg::sizeLine) ? `LINE_BEATS : 1;
        for (int i = 0; i < 4; i++) beatData[i] = $urandom;
        beats = 0;
        clk   = 0;
        idle  = 0;
        done  = 1'b0;
        @(posedge CLK40);
        nTS     <= 1'b0;
        address <= addr;
        nRW     <= !write;
        siz     <= size;
        dataIn  <= beatData[0];
        @(posedge CLK40);   // The DUT samples nTS here
        nTS <= 1'b1;
        while (!done) begin
            @(negedge CLK40);
            if (clk >= 1) begin
                // The space is selected from the clock after transfer start
                assert (taDrive) else begin
                    $display("ERROR at %0t: nTA not driven at clock %0d of cycle to %h",
                             $time, clk, addr);
                    protocolErrors++;
                end
            end
            if (!nTA) begin
                assert (beats < wantBeats && clk == firstClk + beats) else begin
                    $display("ERROR at %0t: unexpected nTA at clock %0d of cycle to %h",
                             $time, clk, addr);
                    protocolErrors++;
                end
                assert (nTBI != inhibit && tbiDrive) else begin
                    $display("ERROR at %0t: wrong burst inhibit on cycle to %h", $time, addr);
                    protocolErrors++;
                end
                if (write) begin
                    recordWrite(addr, size, beats, beatData[beats % 4]);
                end else begin
                    gotQ.push_back(dataOut);
                    wantQ.push_back(expectRead(addr, size, beats));
                end
                beats++;
                idle = 0;
                done = (beats == wantBeats);
            end
            if (!nTEA) begin
                assert (kind == cpuBusPkg::spaceBad && clk == firstClk) else begin
                    $display("ERROR at %0t: unexpected nTEA on cycle to %h", $time, addr);
                    protocolErrors++;
                end
                done = 1'b1;   // A transfer error always ends the cycle
            end
            if (!done) begin
                idle++;
                assert (idle <= 10) else begin
                    $display("ERROR at %0t: no acknowledge within 10 clocks on cycle to %h",
                             $time, addr);
                    protocolErrors++;
                end
                if (idle > 10) return;
                @(posedge CLK40);
                if (write && beats < 4) dataIn <= beatData[beats];   // Next beat's data
                clk++;
            end
        end
        @(posedge CLK40);
        @(negedge CLK40);
        assert (taDrive && nTA && nTEA) else begin
            $display("ERROR at %0t: nTA not driven high after cycle to %h", $time, addr);
            protocolErrors++;
        end
        @(posedge CLK40);
        @(negedge CLK40);
        assert (!taDrive && !tbiDrive) else begin
            $display("ERROR at %0t: drive enables still high after cycle to %h", $time, addr);
            protocolErrors++;
        end
    endtask

    task automatic runRandomCycle();
        int                 pick;
        cpuBusPkg::cpuAddr  addr;
        cpuBusPkg::sizeCode size;
        pick = int'($urandom % 3);
        if (pick == 0)
            addr = `REG_BASE + {27'd0, 3'($urandom), 2'b00};
        else if (pick == 1)
            addr = `RAM_BASE + {22'd0, 8'($urandom), 2'b00};
        else
            addr = 32'h4000_0000 | {4'd0, 26'($urandom), 2'b00};   // Far above both windows
        size = ($urandom % 2 == 0) ? cpuBusPkg::sizeLine
                                   : cpuBusPkg::sizeCode'(2'($urandom % 3));
        runCycle(addr, 1'($urandom % 2), size);
    endtask

    // Compare process for the read beats
    always @(posedge CLK40) begin
        while (gotQ.size() > 0) begin
            got  = gotQ.pop_front();
            want = wantQ.pop_front();
            assert (got === want) else begin
                $display("MISMATCH at %0t: read %h, expected %h", $time, got, want);
                mismatches++;
            end
        end
    end

    //////////////////////
    // Test sequence
    //////////////////////

    initial begin
        void'($urandom(32'h76ff_e921));
        nRESET  = 1'b0;
        nTS     = 1'b1;
        address = '0;
        nRW     = 1'b1;
        siz     = cpuBusPkg::sizeLong;
        dataIn  = '0;
        for (int i = 0; i < 8; i++) regModel[i] = '0;   // Registers come out of reset cleared
        repeat (3) @(posedge CLK40);
        nRESET <= 1'b1;
        @(negedge CLK40);
        assert (nTA && nTBI && nTEA && !taDrive && !tbiDrive) else begin
            $display("ERROR at %0t: bus lines not idle after reset", $time);
            protocolErrors++;
        end

        runCycle(`REG_BASE + 32'h14, 1'b1, cpuBusPkg::sizeLong);
        runCycle(`REG_BASE + 32'h14, 1'b0, cpuBusPkg::sizeLong);
        runCycle(`REG_BASE + 32'h08, 1'b1, cpuBusPkg::sizeLine);   // Single beat with nTBI
        runCycle(`REG_BASE + 32'h08, 1'b0, cpuBusPkg::sizeLine);

        for (int i = 0; i < preloadLines; i++)
            runCycle(`RAM_BASE + 32'(i * 16), 1'b1, cpuBusPkg::sizeLine);
        for (int i = 0; i < randomWrites; i++) begin
            testAddr[i] = `RAM_BASE + {22'd0, 8'($urandom), 2'b00};
            testSize[i] = (i % 2 == 1) ? cpuBusPkg::sizeLine
                                       : cpuBusPkg::sizeCode'(2'($urandom % 3));
            runCycle(testAddr[i], 1'b1, testSize[i]);
        end
        for (int i = 0; i < randomWrites; i++)
            runCycle(testAddr[i], 1'b0, testSize[i]);

        runCycle(32'h4000_0100, 1'b0, cpuBusPkg::sizeLong);
        runCycle(32'h4000_0200, 1'b1, cpuBusPkg::sizeLine);

        for (int i = 0; i < mixedCycles; i++)
            runRandomCycle();

        repeat (2) @(posedge CLK40);   // Let the compare process drain its queue
        $display("Errors: %0d data mismatches, %0d protocol errors", mismatches, protocolErrors);
        if (mismatches == 0 && protocolErrors == 0 && gotQ.size() == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // Watchdog sized from the number of issued cycles
    initial begin
        #(200 * totalCycles * clkPeriod);
        $display("Watchdog expired after %0d clocks, the test did not finish", 200 * totalCycles);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+src
src/cpuBusPkg.sv
src/addressDecode.sv
src/registerSpace.sv
src/ramCycle.sv
src/transferAck.sv
src/cpuBusTop.sv
bench/tbCpuBus.sv

// ==== run.sh ====
#!/bin/sh
# Build the CPU bus testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tbCpuBus -f list.f -o tbCpuBus
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tbCpuBus > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^STATUS: PASS$" "$LOG"; then
    exit 0
fi

echo "Pass message not found in $LOG"
exit 1

// ==== src/addressDecode.sv ====
////////////////////
// Address decoder
// Latches a cycle on transfer start and holds its space until it ends
////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "cpuBus_params.svh"

module addressDecode (
    input  wire                       CLK40,
    input  wire                       nRESET,
    input  wire                       nTS,
    input  wire cpuBusPkg::cpuAddr    address,
    input  wire                       nRW,
    input  wire cpuBusPkg::sizeCode   siz,
    input  wire                       cycleDone,
    output cpuBusPkg::busCycle        cycle,
    output cpuBusPkg::busSpace        space
);

    logic pending;   // Attributes are latched and the space is decoded next clock
    logic acceptTs;

    // Only one cycle is in flight, so a start during a cycle is dropped
    assign acceptTs = !nTS && !pending && (space == cpuBusPkg::spaceNone);

    function automatic cpuBusPkg::busSpace decodeSpace(input cpuBusPkg::cpuAddr addr);
        cpuBusPkg::cpuAddr ramOffset;
        ramOffset = addr - `RAM_BASE;
        if ((addr & `REG_MASK) == `REG_BASE)
            decodeSpace = cpuBusPkg::spaceReg;
        else if ((ramOffset >> 2) < 32'(`RAM_WORDS))
            decodeSpace = cpuBusPkg::spaceRam;
        else
            decodeSpace = cpuBusPkg::spaceBad;   // Nothing answers here
    endfunction

    // Cycle attributes, valid from the clock after transfer start
    always_ff @(posedge CLK40) begin
        if (acceptTs) begin
            cycle <= '{addr: address, write: !nRW, size: siz};
        end
    end

    always_ff @(posedge CLK40 or negedge nRESET) begin
        if (!nRESET) begin
            pending <= 1'b0;
            space   <= cpuBusPkg::spaceNone;
        end else begin
            pending <= acceptTs;
            if (pending) begin
                space <= decodeSpace(cycle.addr);   // Compare against the latched address
            end else if (cycleDone) begin
                space <= cpuBusPkg::spaceNone;      // Cycle is over, back to idle
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/cpuBusPkg.sv ====
////////////////////
// CPU bus types
// Vector widths, encodings and the latched cycle shared by all blocks
////////////////////
`default_nettype none

package cpuBusPkg;

    typedef logic [31:0] cpuAddr;    // Byte address as driven by the CPU
    typedef logic [31:0] cpuData;    // All transfers are longwords
    typedef logic [7:0]  ramIndex;   // Longword index into the 1 KB RAM
    typedef logic [2:0]  regIndex;   // One of eight control registers
    typedef logic [1:0]  beatCount;  // Beat number inside a line

    // SIZ pin encoding of the 68040
    typedef enum logic [1:0] {
        sizeLong = 2'b00,
        sizeByte = 2'b01,
        sizeWord = 2'b10,
        sizeLine = 2'b11
    } sizeCode;

    // Classification of the current cycle by the decoder
    typedef enum logic [1:0] {
        spaceNone = 2'b00,   // No cycle in flight
        spaceReg  = 2'b01,
        spaceRam  = 2'b10,
        spaceBad  = 2'b11    // Unmapped, ends with a transfer error
    } busSpace;

    // Attributes captured on transfer start and held for the whole cycle
    typedef struct packed {
        cpuAddr  addr;
        logic    write;      // Inverse of nRW
        sizeCode size;
    } busCycle;

endpackage

`default_nettype wire

// ==== src/cpuBusTop.sv ====
////////////////////
// CPU local-bus controller
// Decoder, register and RAM targets and the acknowledge logic
////////////////////
`timescale 1ns/1ps
`default_nettype none

module cpuBusTop (
    input  wire                       CLK40,
    input  wire                       nRESET,
    input  wire                       nTS,
    input  wire cpuBusPkg::cpuAddr    address,
    input  wire                       nRW,
    input  wire cpuBusPkg::sizeCode   siz,
    input  wire cpuBusPkg::cpuData    dataIn,
    output cpuBusPkg::cpuData         dataOut,
    output logic                      nTA,
    output logic                      taDrive,
    output logic                      nTBI,
    output logic                      tbiDrive,
    output logic                      nTEA
);

    cpuBusPkg::busCycle cycle;
    cpuBusPkg::busSpace space;
    cpuBusPkg::cpuData  regData;
    cpuBusPkg::cpuData  ramData;
    logic               regAck;
    logic               ramAck;
    logic               ramLast;
    logic               cycleDone;

    addressDecode decode0 (
        .CLK40(CLK40), .nRESET(nRESET), .nTS(nTS), .address(address), .nRW(nRW),
        .siz(siz), .cycleDone(cycleDone), .cycle(cycle), .space(space)
    );

    registerSpace regs0 (
        .CLK40(CLK40), .nRESET(nRESET), .space(space), .cycle(cycle), .dataIn(dataIn),
        .regAck(regAck), .regData(regData)
    );

    ramCycle ram0 (
        .CLK40(CLK40), .nRESET(nRESET), .space(space), .cycle(cycle), .dataIn(dataIn),
        .ramAck(ramAck), .ramLast(ramLast), .ramData(ramData)
    );

    transferAck ack0 (
        .CLK40(CLK40), .nRESET(nRESET), .space(space), .size(cycle.size),
        .regAck(regAck), .ramAck(ramAck), .ramLast(ramLast), .nTA(nTA),
        .taDrive(taDrive), .nTBI(nTBI), .tbiDrive(tbiDrive), .nTEA(nTEA),
        .cycleDone(cycleDone)
    );

    // Read data follows the selected target
    always_comb begin
        case (space)
            cpuBusPkg::spaceReg: dataOut = regData;
            cpuBusPkg::spaceRam: dataOut = ramData;
            default:             dataOut = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== src/cpuBus_params.svh ====
////////////////////
// CPU bus parameters
// Address map, memory sizes and wait states of the local-bus targets
////////////////////
`ifndef CPUBUS_PARAMS_SVH
`define CPUBUS_PARAMS_SVH

// Control register window of eight longwords
`define REG_BASE        32'h00F0_0000
`define REG_MASK        32'hFFFF_FFE0   // Address bits that must match REG_BASE

// On-chip RAM window starting at the bottom of the map
`define RAM_BASE        32'h0000_0000
`define RAM_WORDS       256             // Longwords, so the window is 1 KB

// Wait states counted from the clock that latches the cycle
`define REG_WAIT        2
`define RAM_FIRST_WAIT  3               // Latency of the first beat only

// A line transfer is always four longwords on this bus
`define LINE_BEATS      4

`endif

// ==== src/ramCycle.sv ====
////////////////////
// On-chip RAM target
// Longword RAM with a first-beat latency and single or line bursts
////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "cpuBus_params.svh"

module ramCycle (
    input  wire                       CLK40,
    input  wire                       nRESET,
    input  wire cpuBusPkg::busSpace   space,
    input  wire cpuBusPkg::busCycle   cycle,
    input  wire cpuBusPkg::cpuData    dataIn,
    output logic                      ramAck,
    output logic                      ramLast,
    output cpuBusPkg::cpuData         ramData
);

    typedef enum logic [1:0] {
        ramIdle,
        ramLatency,
        ramBurst
    } ramState;

    ramState             state;
    logic [2:0]          waitCnt;    // Clocks spent since the space was latched
    cpuBusPkg::beatCount beat;       // Beat being transferred while ramAck is high
    cpuBusPkg::beatCount nextBeat;
    cpuBusPkg::ramIndex  wordIdx;
    logic                isLine;

    cpuBusPkg::cpuData   ramMem [`RAM_WORDS];

    assign isLine   = (cycle.size == cpuBusPkg::sizeLine);
    assign nextBeat = beat + 2'd1;

    // A line runs through its four longwords from the aligned start
    assign wordIdx = isLine ? {cycle.addr[9:4], beat} : cycle.addr[9:2];

    //////////////////////
    // Beat sequencer
    //////////////////////

    always_ff @(posedge CLK40 or negedge nRESET) begin
        if (!nRESET) begin
            state   <= ramIdle;
            waitCnt <= 3'd0;
            beat    <= '0;
            ramAck  <= 1'b0;
            ramLast <= 1'b0;
        end else begin
            case (state)
                ramIdle: begin
                    beat <= '0;                // Every burst starts at the first word
                    if (space == cpuBusPkg::spaceRam) begin
                        waitCnt <= 3'd1;
                        state   <= ramLatency;
                    end
                end
                ramLatency: begin
                    if (waitCnt == 3'(`RAM_FIRST_WAIT - 1)) begin
                        ramAck  <= 1'b1;
                        ramLast <= !isLine;    // A single transfer ends on its first beat
                        state   <= ramBurst;
                    end else begin
                        waitCnt <= waitCnt + 3'd1;
                    end
                end
                ramBurst: begin
                    if (ramLast) begin
                        // Final beat went out, the decoder drops the space on this edge
                        ramAck  <= 1'b0;
                        ramLast <= 1'b0;
                        state   <= ramIdle;
                    end else begin
                        beat    <= nextBeat;   // One beat per clock, no wait states
                        ramLast <= (nextBeat == cpuBusPkg::beatCount'(`LINE_BEATS - 1));
                    end
                end
                default: state <= ramIdle;
            endcase
        end
    end

    //////////////////////
    // Memory array
    //////////////////////

    always_ff @(posedge CLK40) begin
        if (ramAck && cycle.write) begin
            ramMem[wordIdx] <= dataIn;   // The CPU holds each beat's data with its nTA
        end
    end

    assign ramData = ramMem[wordIdx];   // Read beat data follows the beat counter

endmodule

`default_nettype wire

// ==== src/registerSpace.sv ====
////////////////////
// Register space
// Eight control registers answered after a fixed number of wait states
////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "cpuBus_params.svh"

module registerSpace (
    input  wire                       CLK40,
    input  wire                       nRESET,
    input  wire cpuBusPkg::busSpace   space,
    input  wire cpuBusPkg::busCycle   cycle,
    input  wire cpuBusPkg::cpuData    dataIn,
    output logic                      regAck,
    output cpuBusPkg::cpuData         regData
);

    typedef enum logic [1:0] {
        regIdle,
        regWait,
        regDone
    } regState;

    regState           state;
    logic [1:0]        waitCnt;       // Clocks spent since the space was latched
    cpuBusPkg::regIndex regSel;
    cpuBusPkg::cpuData regFile [8];

    assign regSel  = cycle.addr[4:2];  // Longword offset inside the window
    assign regData = regFile[regSel];  // Read data is sampled by the CPU with nTA

    //////////////////////
    // Acknowledge FSM
    //////////////////////

    always_ff @(posedge CLK40 or negedge nRESET) begin
        if (!nRESET) begin
            state   <= regIdle;
            waitCnt <= 2'd0;
            regAck  <= 1'b0;
        end else begin
            case (state)
                regIdle: begin
                    if (space == cpuBusPkg::spaceReg) begin
                        waitCnt <= 2'd1;   // The clock that saw the space counts as one
                        state   <= regWait;
                    end
                end
                regWait: begin
                    if (waitCnt == 2'(`REG_WAIT - 1)) begin
                        regAck <= 1'b1;    // Single beat, the decoder clears the space on it
                        state  <= regDone;
                    end else begin
                        waitCnt <= waitCnt + 2'd1;
                    end
                end
                regDone: begin
                    regAck <= 1'b0;
                    state  <= regIdle;     // Space is already back to none here
                end
                default: state <= regIdle;
            endcase
        end
    end

    //////////////////////
    // Register file
    //////////////////////

    always_ff @(posedge CLK40 or negedge nRESET) begin
        if (!nRESET) begin
            for (int i = 0; i < 8; i++) begin
                regFile[i] <= '0;
            end
        end else if (regAck && cycle.write) begin
            regFile[regSel] <= dataIn;   // Write data is valid in the acknowledge clock
        end
    end

endmodule

`default_nettype wire

// ==== src/transferAck.sv ====
////////////////////
// 68040 transfer acknowledge
// Merges target acknowledges into nTA, nTBI and nTEA with drive enables
////////////////////
`timescale 1ns/1ps
`default_nettype none

module transferAck (
    input  wire                       CLK40,
    input  wire                       nRESET,
    input  wire cpuBusPkg::busSpace   space,
    input  wire cpuBusPkg::sizeCode   size,
    input  wire                       regAck,
    input  wire                       ramAck,
    input  wire                       ramLast,
    output logic                      nTA,
    output logic                      taDrive,
    output logic                      nTBI,
    output logic                      tbiDrive,
    output logic                      nTEA,
    output logic                      cycleDone
);

    logic anyAck;
    logic spaceSel;
    logic taCycle;   // Keeps nTA driven high for one clock after the cycle ends
    logic badSeen;   // Error clock of an unmapped cycle

    assign anyAck   = regAck | ramAck;
    assign spaceSel = (space != cpuBusPkg::spaceNone);

    // Last beat of either target, or the error clock of an unmapped cycle
    assign cycleDone = regAck | ramLast | badSeen;

    assign nTA     = !anyAck;              // One low clock per transferred beat
    assign taDrive = spaceSel | taCycle;   // The trailing clock stops the next cycle ending early

    // Registers cannot burst, so a line request ends after its first beat
    assign nTBI     = !(regAck && (size == cpuBusPkg::sizeLine));
    assign tbiDrive = taDrive;

    assign nTEA = !badSeen;

    always_ff @(posedge CLK40 or negedge nRESET) begin
        if (!nRESET) begin
            taCycle <= 1'b0;
            badSeen <= 1'b0;
        end else begin
            taCycle <= cycleDone;
            badSeen <= (space == cpuBusPkg::spaceBad) && !badSeen;   // Single clock pulse
        end
    end

endmodule

`default_nettype wire
